//--- rtl/dnn_pkg.sv
// DNN memory subsystem package with data widths, register map and job states
`default_nettype none

package dnn_pkg;

    // Lane layout of a memory word
    localparam int LANES      = 4;
    localparam int X_BITS     = 8;
    localparam int K_BITS     = 8;
    localparam int Y_BITS     = 8;
    localparam int WORD_BITS  = LANES * X_BITS;
    localparam int SHIFT_BITS = 4;

    // Configuration register map
    typedef enum logic [2:0] {
        REG_PIX_BASE = 3'd0,
        REG_WGT_BASE = 3'd1,
        REG_OUT_BASE = 3'd2,
        REG_COUNT    = 3'd3,
        REG_SHIFT    = 3'd4,
        REG_START    = 3'd5
    } cfg_reg_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } job_state_e;

endpackage

`default_nettype wire

//--- rtl/dnn_credit_fifo.sv
// Credit FIFO that buffers a stream and returns one credit per pop
`default_nettype none
`timescale 1ns/100ps

module dnn_credit_fifo #(
    parameter int DEPTH = 4,
    parameter int WIDTH = 32
) (
    input  wire              clk,
    input  wire              i_rst_n,
    input  wire              i_push,
    input  wire [WIDTH-1:0]  i_data,
    input  wire              i_pop,
    output logic [WIDTH-1:0] o_data,
    output logic             o_empty,
    output logic             o_credit
);
    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]    mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] level;
    logic                full;

    assign full    = (level == CNT_BITS'(DEPTH));
    assign o_empty = (level == '0);
    assign o_data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            level    <= '0;
            o_credit <= 1'b0;
        end else begin
            // Credit goes back to the sender one cycle after the pop
            o_credit <= i_pop;
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            level <= level + CNT_BITS'(i_push) - CNT_BITS'(i_pop);
        end
    end

    // Sender credits must keep the buffer from overflowing
    a_no_overrun: assert property (@(posedge clk) disable iff (!i_rst_n)
        !(i_push && full) && !(i_pop && o_empty))
        else $error("credit fifo overrun or underrun");

endmodule

`default_nettype wire

//--- rtl/dnn_cfg_regs.sv
// Configuration registers with job start pulse and job state machine
`default_nettype none
`timescale 1ns/100ps

module dnn_cfg_regs #(
    parameter int ADDR_BITS = 12
) (
    input  wire                             clk,
    input  wire                             i_rst_n,
    input  wire                             i_cfg_we,
    input  wire dnn_pkg::cfg_reg_e          i_cfg_addr,
    input  wire [dnn_pkg::WORD_BITS-1:0]    i_cfg_wdata,
    input  wire                             i_job_last,
    output logic                            o_start,
    output logic [ADDR_BITS-1:0]            o_pix_base,
    output logic [ADDR_BITS-1:0]            o_wgt_base,
    output logic [ADDR_BITS-1:0]            o_out_base,
    output logic [ADDR_BITS-1:0]            o_count,
    output logic [dnn_pkg::SHIFT_BITS-1:0]  o_shift,
    output logic                            o_busy,
    output logic                            o_done
);
    dnn_pkg::job_state_e state;

    logic [ADDR_BITS-1:0]           pix_base_q;
    logic [ADDR_BITS-1:0]           wgt_base_q;
    logic [ADDR_BITS-1:0]           out_base_q;
    logic [ADDR_BITS-1:0]           count_q;
    logic [dnn_pkg::SHIFT_BITS-1:0] shift_q;
    logic                           start_ok;

    // Start is ignored while a job runs
    assign start_ok = i_cfg_we && (i_cfg_addr == dnn_pkg::REG_START) &&
                      (state != dnn_pkg::ST_RUN);
    assign o_busy   = (state == dnn_pkg::ST_RUN);

    // Shadow copies, written at any time
    always_ff @(posedge clk) begin
        if (i_cfg_we) begin
            case (i_cfg_addr)
                dnn_pkg::REG_PIX_BASE: pix_base_q <= i_cfg_wdata[ADDR_BITS-1:0];
                dnn_pkg::REG_WGT_BASE: wgt_base_q <= i_cfg_wdata[ADDR_BITS-1:0];
                dnn_pkg::REG_OUT_BASE: out_base_q <= i_cfg_wdata[ADDR_BITS-1:0];
                dnn_pkg::REG_COUNT:    count_q    <= i_cfg_wdata[ADDR_BITS-1:0];
                dnn_pkg::REG_SHIFT:    shift_q    <= i_cfg_wdata[dnn_pkg::SHIFT_BITS-1:0];
                default:               ;
            endcase
        end
    end

    // Job parameters stay fixed for the whole job
    always_ff @(posedge clk) begin
        if (start_ok) begin
            o_pix_base <= pix_base_q;
            o_wgt_base <= wgt_base_q;
            o_out_base <= out_base_q;
            o_count    <= count_q;
            o_shift    <= shift_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state   <= dnn_pkg::ST_IDLE;
            o_start <= 1'b0;
            o_done  <= 1'b0;
        end else begin
            o_start <= start_ok;
            o_done  <= i_job_last;
            case (state)
                dnn_pkg::ST_IDLE, dnn_pkg::ST_DONE: begin
                    if (start_ok) begin
                        state <= dnn_pkg::ST_RUN;
                    end
                end
                dnn_pkg::ST_RUN: begin
                    if (i_job_last) begin
                        state <= dnn_pkg::ST_DONE;
                    end
                end
                default: state <= dnn_pkg::ST_IDLE;
            endcase
        end
    end

    a_last_in_run: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_job_last |-> state == dnn_pkg::ST_RUN)
        else $error("write DMA finished outside a running job");

endmodule

`default_nettype wire

//--- rtl/dnn_read_dma.sv
// Read DMA that fetches sequential words and streams them under credits
`default_nettype none
`timescale 1ns/100ps

module dnn_read_dma #(
    parameter int ADDR_BITS  = 12,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                           clk,
    input  wire                           i_rst_n,
    input  wire                           i_start,
    input  wire [ADDR_BITS-1:0]           i_base,
    input  wire [ADDR_BITS-1:0]           i_count,
    input  wire                           i_grant,
    input  wire [dnn_pkg::WORD_BITS-1:0]  i_rdata,
    input  wire                           i_credit,
    output logic                          o_rd,
    output logic [ADDR_BITS-1:0]          o_raddr,
    output logic                          o_valid,
    output logic [dnn_pkg::WORD_BITS-1:0] o_data
);
    localparam int CRD_BITS = $clog2(FIFO_DEPTH + 1);

    logic [CRD_BITS-1:0]  credits;
    logic [ADDR_BITS-1:0] remain;
    logic                 issue;

    // A new request may follow a granted one back to back
    assign issue  = (!o_rd || i_grant) && (remain != '0) && (credits != '0);
    assign o_data = i_rdata;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_rd    <= 1'b0;
            o_valid <= 1'b0;
            remain  <= '0;
            credits <= CRD_BITS'(FIFO_DEPTH);
        end else begin
            o_valid <= o_rd && i_grant;
            if (issue) begin
                o_rd <= 1'b1;
            end else if (i_grant) begin
                o_rd <= 1'b0;
            end
            if (i_start) begin
                remain <= i_count;
            end else if (issue) begin
                remain <= remain - 1'b1;
            end
            // Credit reserved at request time
            credits <= credits - CRD_BITS'(issue) + CRD_BITS'(i_credit);
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            o_raddr <= i_base;
        end else if (o_rd && i_grant) begin
            o_raddr <= o_raddr + 1'b1;
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!i_rst_n)
        credits <= CRD_BITS'(FIFO_DEPTH))
        else $error("receiver returned more credits than it was given");

endmodule

`default_nettype wire

//--- rtl/dnn_mac_engine.sv
// Lane multiply engine with shift, ReLU and saturation over two stages
`default_nettype none
`timescale 1ns/100ps

module dnn_mac_engine #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire                             clk,
    input  wire                             i_rst_n,
    input  wire [dnn_pkg::SHIFT_BITS-1:0]   i_shift,
    input  wire                             i_pix_valid,
    input  wire [dnn_pkg::WORD_BITS-1:0]    i_pix_data,
    input  wire                             i_wgt_valid,
    input  wire [dnn_pkg::WORD_BITS-1:0]    i_wgt_data,
    input  wire                             i_out_credit,
    output logic                            o_pix_credit,
    output logic                            o_wgt_credit,
    output logic                            o_out_valid,
    output logic [dnn_pkg::WORD_BITS-1:0]   o_out_data
);
    localparam int P_BITS   = dnn_pkg::X_BITS + dnn_pkg::K_BITS;
    localparam int Y_BITS   = dnn_pkg::Y_BITS;
    localparam int CRD_BITS = $clog2(FIFO_DEPTH + 1);

    logic [dnn_pkg::WORD_BITS-1:0] pix_word;
    logic [dnn_pkg::WORD_BITS-1:0] wgt_word;
    logic                          pix_empty;
    logic                          wgt_empty;
    logic                          pop;
    logic [CRD_BITS-1:0]           out_credits;
    logic signed [P_BITS-1:0]      s1_prod [dnn_pkg::LANES];
    logic                          s1_valid;
    wire  [dnn_pkg::WORD_BITS-1:0] s2_word;

    dnn_credit_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(dnn_pkg::WORD_BITS)) u_pix_fifo (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_push   (i_pix_valid),
        .i_data   (i_pix_data),
        .i_pop    (pop),
        .o_data   (pix_word),
        .o_empty  (pix_empty),
        .o_credit (o_pix_credit)
    );

    dnn_credit_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(dnn_pkg::WORD_BITS)) u_wgt_fifo (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_push   (i_wgt_valid),
        .i_data   (i_wgt_data),
        .i_pop    (pop),
        .o_data   (wgt_word),
        .o_empty  (wgt_empty),
        .o_credit (o_wgt_credit)
    );

    // Pop only with a slot reserved downstream
    assign pop = !pix_empty && !wgt_empty && (out_credits != '0);

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            s1_valid    <= 1'b0;
            o_out_valid <= 1'b0;
            out_credits <= CRD_BITS'(FIFO_DEPTH);
        end else begin
            s1_valid    <= pop;
            o_out_valid <= s1_valid;
            out_credits <= out_credits - CRD_BITS'(pop) + CRD_BITS'(i_out_credit);
        end
    end

    // Stage one, signed lane products
    always_ff @(posedge clk) begin
        if (pop) begin
            for (int l = 0; l < dnn_pkg::LANES; l++) begin
                s1_prod[l] <= $signed(pix_word[l*dnn_pkg::X_BITS +: dnn_pkg::X_BITS]) *
                              $signed(wgt_word[l*dnn_pkg::K_BITS +: dnn_pkg::K_BITS]);
            end
        end
        if (s1_valid) begin
            o_out_data <= s2_word;
        end
    end

    // Stage two, shift then ReLU then clamp to the top code
    for (genvar l = 0; l < dnn_pkg::LANES; l++) begin : g_lane
        logic signed [P_BITS-1:0] shifted;

        assign shifted = s1_prod[l] >>> i_shift;
        assign s2_word[l*Y_BITS +: Y_BITS] = shifted[P_BITS-1]          ? '0 :
                                             (|shifted[P_BITS-2:Y_BITS]) ? '1 :
                                             shifted[Y_BITS-1:0];
    end

endmodule

`default_nettype wire

//--- rtl/dnn_write_dma.sv
// Write DMA that stores stream words to sequential addresses and ends the job
`default_nettype none
`timescale 1ns/100ps

module dnn_write_dma #(
    parameter int ADDR_BITS  = 12,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                           clk,
    input  wire                           i_rst_n,
    input  wire                           i_start,
    input  wire [ADDR_BITS-1:0]           i_base,
    input  wire [ADDR_BITS-1:0]           i_count,
    input  wire                           i_valid,
    input  wire [dnn_pkg::WORD_BITS-1:0]  i_data,
    input  wire                           i_grant,
    output logic                          o_credit,
    output logic                          o_we,
    output logic [ADDR_BITS-1:0]          o_waddr,
    output logic [dnn_pkg::WORD_BITS-1:0] o_wdata,
    output logic                          o_job_last
);
    logic [dnn_pkg::WORD_BITS-1:0] fifo_word;
    logic                          fifo_empty;
    logic                          pop;
    logic [ADDR_BITS-1:0]          remain;

    dnn_credit_fifo #(.DEPTH(FIFO_DEPTH), .WIDTH(dnn_pkg::WORD_BITS)) u_out_fifo (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_push   (i_valid),
        .i_data   (i_data),
        .i_pop    (pop),
        .o_data   (fifo_word),
        .o_empty  (fifo_empty),
        .o_credit (o_credit)
    );

    // Refill the write register as soon as it empties
    assign pop        = !fifo_empty && (!o_we || i_grant);
    assign o_job_last = o_we && i_grant && (remain == ADDR_BITS'(1));

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_we   <= 1'b0;
            remain <= '0;
        end else begin
            if (pop) begin
                o_we <= 1'b1;
            end else if (i_grant) begin
                o_we <= 1'b0;
            end
            if (i_start) begin
                remain <= i_count;
            end else if (o_we && i_grant) begin
                remain <= remain - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            o_wdata <= fifo_word;
        end
        if (i_start) begin
            o_waddr <= i_base;
        end else if (o_we && i_grant) begin
            o_waddr <= o_waddr + 1'b1;
        end
    end

    a_hold_write: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_we && !i_grant |=> o_we && $stable(o_waddr) && $stable(o_wdata))
        else $error("write request changed before grant");

endmodule

`default_nettype wire

//--- rtl/dnn_mem_top.sv
// Memory-side top joining registers, read DMAs, MAC engine and write DMA
`default_nettype none
`timescale 1ns/100ps

module dnn_mem_top #(
    parameter int ADDR_BITS  = 12,
    parameter int FIFO_DEPTH = 4
) (
    input  wire                           clk,
    input  wire                           i_rst_n,
    input  wire                           i_cfg_we,
    input  wire dnn_pkg::cfg_reg_e        i_cfg_addr,
    input  wire [dnn_pkg::WORD_BITS-1:0]  i_cfg_wdata,
    input  wire                           i_pix_grant,
    input  wire [dnn_pkg::WORD_BITS-1:0]  i_pix_rdata,
    input  wire                           i_wgt_grant,
    input  wire [dnn_pkg::WORD_BITS-1:0]  i_wgt_rdata,
    input  wire                           i_out_grant,
    output logic                          o_pix_rd,
    output logic [ADDR_BITS-1:0]          o_pix_raddr,
    output logic                          o_wgt_rd,
    output logic [ADDR_BITS-1:0]          o_wgt_raddr,
    output logic                          o_out_we,
    output logic [ADDR_BITS-1:0]          o_out_waddr,
    output logic [dnn_pkg::WORD_BITS-1:0] o_out_wdata,
    output logic                          o_busy,
    output logic                          o_done
);
    logic                           start;
    logic [ADDR_BITS-1:0]           pix_base;
    logic [ADDR_BITS-1:0]           wgt_base;
    logic [ADDR_BITS-1:0]           out_base;
    logic [ADDR_BITS-1:0]           count;
    logic [dnn_pkg::SHIFT_BITS-1:0] shift;
    logic                           job_last;
    logic                           pix_valid;
    logic [dnn_pkg::WORD_BITS-1:0]  pix_data;
    logic                           pix_credit;
    logic                           wgt_valid;
    logic [dnn_pkg::WORD_BITS-1:0]  wgt_data;
    logic                           wgt_credit;
    logic                           out_valid;
    logic [dnn_pkg::WORD_BITS-1:0]  out_data;
    logic                           out_credit;

    dnn_cfg_regs #(.ADDR_BITS(ADDR_BITS)) u_cfg_regs (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_cfg_we(i_cfg_we), .i_cfg_addr(i_cfg_addr), .i_cfg_wdata(i_cfg_wdata),
        .i_job_last(job_last), .o_start(start),
        .o_pix_base(pix_base), .o_wgt_base(wgt_base), .o_out_base(out_base),
        .o_count(count), .o_shift(shift), .o_busy(o_busy), .o_done(o_done)
    );

    dnn_read_dma #(.ADDR_BITS(ADDR_BITS), .FIFO_DEPTH(FIFO_DEPTH)) u_pix_dma (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(start), .i_base(pix_base), .i_count(count),
        .i_grant(i_pix_grant), .i_rdata(i_pix_rdata), .i_credit(pix_credit),
        .o_rd(o_pix_rd), .o_raddr(o_pix_raddr), .o_valid(pix_valid), .o_data(pix_data)
    );

    dnn_read_dma #(.ADDR_BITS(ADDR_BITS), .FIFO_DEPTH(FIFO_DEPTH)) u_wgt_dma (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(start), .i_base(wgt_base), .i_count(count),
        .i_grant(i_wgt_grant), .i_rdata(i_wgt_rdata), .i_credit(wgt_credit),
        .o_rd(o_wgt_rd), .o_raddr(o_wgt_raddr), .o_valid(wgt_valid), .o_data(wgt_data)
    );

    dnn_mac_engine #(.FIFO_DEPTH(FIFO_DEPTH)) u_engine (
        .clk(clk), .i_rst_n(i_rst_n), .i_shift(shift),
        .i_pix_valid(pix_valid), .i_pix_data(pix_data),
        .i_wgt_valid(wgt_valid), .i_wgt_data(wgt_data),
        .i_out_credit(out_credit), .o_pix_credit(pix_credit), .o_wgt_credit(wgt_credit),
        .o_out_valid(out_valid), .o_out_data(out_data)
    );

    dnn_write_dma #(.ADDR_BITS(ADDR_BITS), .FIFO_DEPTH(FIFO_DEPTH)) u_out_dma (
        .clk(clk), .i_rst_n(i_rst_n), .i_start(start), .i_base(out_base), .i_count(count),
        .i_valid(out_valid), .i_data(out_data), .i_grant(i_out_grant),
        .o_credit(out_credit), .o_we(o_out_we), .o_waddr(o_out_waddr),
        .o_wdata(o_out_wdata), .o_job_last(job_last)
    );

endmodule

`default_nettype wire

//--- testbench/dnn_checker.sv
// Checker that compares DUT writes, busy and done with a reference model
`default_nettype none
`timescale 1ns/100ps

module dnn_checker #(
    parameter int ADDR_BITS = 12
) (
    input wire                          clk,
    input wire                          i_rst_n,
    input wire                          i_cfg_we,
    input wire dnn_pkg::cfg_reg_e       i_cfg_addr,
    input wire                          i_pix_rd,
    input wire [ADDR_BITS-1:0]          i_pix_raddr,
    input wire                          i_pix_grant,
    input wire                          i_wgt_rd,
    input wire [ADDR_BITS-1:0]          i_wgt_raddr,
    input wire                          i_wgt_grant,
    input wire                          i_out_we,
    input wire [ADDR_BITS-1:0]          i_out_waddr,
    input wire [dnn_pkg::WORD_BITS-1:0] i_out_wdata,
    input wire                          i_out_grant,
    input wire                          i_busy,
    input wire                          i_done
);
    localparam int YB = dnn_pkg::Y_BITS;
    localparam int XB = dnn_pkg::X_BITS;
    localparam int KB = dnn_pkg::K_BITS;

    // Pending writes in the order the DUT must issue them
    logic [ADDR_BITS-1:0]           exp_addr [$];
    logic [dnn_pkg::WORD_BITS-1:0]  exp_data [$];
    logic                           exp_last [$];
    logic [ADDR_BITS-1:0]           job_base = '0;
    logic [dnn_pkg::SHIFT_BITS-1:0] job_shift = '0;
    int                             job_count = 0;
    int                             job_idx = 0;
    int                             writes = 0;
    int                             value_errors = 0;
    int                             other_errors = 0;
    logic                           busy_exp = 1'b0;
    logic                           done_exp = 1'b0;
    logic                           in_reset_q = 1'b0;
    logic                           pix_wait_q = 1'b0;
    logic                           wgt_wait_q = 1'b0;
    logic [ADDR_BITS-1:0]           pix_addr_q = '0;
    logic [ADDR_BITS-1:0]           wgt_addr_q = '0;

    // Signed product, arithmetic shift, ReLU, clamp to 255
    function automatic logic [YB-1:0] lane_result(input logic signed [XB-1:0] x,
                                                  input logic signed [KB-1:0] k,
                                                  input logic [dnn_pkg::SHIFT_BITS-1:0] shift);
        int prod;
        prod = x * k;
        prod = prod >>> shift;
        if (prod < 0) begin
            return '0;
        end
        if (prod > 255) begin
            return 8'd255;
        end
        return YB'(prod);
    endfunction

    task automatic begin_job(input logic [ADDR_BITS-1:0] out_base, input int count,
                             input logic [dnn_pkg::SHIFT_BITS-1:0] shift);
        job_base  = out_base;
        job_count = count;
        job_shift = shift;
        job_idx   = 0;
    endtask

    task automatic expect_word(input logic [dnn_pkg::WORD_BITS-1:0] pix,
                               input logic [dnn_pkg::WORD_BITS-1:0] wgt);
        logic [dnn_pkg::WORD_BITS-1:0] word;
        for (int l = 0; l < dnn_pkg::LANES; l++) begin
            word[l*YB +: YB] = lane_result(pix[l*XB +: XB], wgt[l*KB +: KB], job_shift);
        end
        exp_addr.push_back(job_base + ADDR_BITS'(job_idx));
        exp_data.push_back(word);
        exp_last.push_back(job_idx == job_count - 1);
        job_idx++;
    endtask

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail %0t ns: %s expected %0h actual %0h", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic record_write();
        writes++;
        if (exp_addr.size() == 0) begin
            $display("Unexpected write to address %0h at %0t ns", i_out_waddr, $time);
            other_errors++;
        end else begin
            compare_value("o_out_waddr", 32'(exp_addr.pop_front()), 32'(i_out_waddr));
            compare_value("o_out_wdata", exp_data.pop_front(), i_out_wdata);
            if (exp_last.pop_front()) begin
                done_exp = 1'b1;
                busy_exp = 1'b0;
            end
        end
    endtask

    task automatic finish_report(output int total);
        if (exp_addr.size() != 0) begin
            $display("%0d expected writes never arrived", exp_addr.size());
            other_errors++;
        end
        $display("Checker summary %0d writes, %0d value errors, %0d other errors",
                 writes, value_errors, other_errors);
        total = value_errors + other_errors;
    endtask

    always @(posedge clk) begin
        // Outputs as left by the reset edge
        if (in_reset_q) begin
            compare_value("o_pix_rd", 32'(1'b0), 32'(i_pix_rd));
            compare_value("o_wgt_rd", 32'(1'b0), 32'(i_wgt_rd));
            compare_value("o_out_we", 32'(1'b0), 32'(i_out_we));
            compare_value("o_busy", 32'(1'b0), 32'(i_busy));
            compare_value("o_done", 32'(1'b0), 32'(i_done));
        end
        in_reset_q = !i_rst_n;
        if (!i_rst_n) begin
            busy_exp   = 1'b0;
            done_exp   = 1'b0;
            pix_wait_q = 1'b0;
            wgt_wait_q = 1'b0;
        end else begin
            compare_value("o_busy", 32'(busy_exp), 32'(i_busy));
            compare_value("o_done", 32'(done_exp), 32'(i_done));
            // Ungranted reads must be held
            if (pix_wait_q) begin
                compare_value("o_pix_rd", 32'(1'b1), 32'(i_pix_rd));
                compare_value("o_pix_raddr", 32'(pix_addr_q), 32'(i_pix_raddr));
            end
            if (wgt_wait_q) begin
                compare_value("o_wgt_rd", 32'(1'b1), 32'(i_wgt_rd));
                compare_value("o_wgt_raddr", 32'(wgt_addr_q), 32'(i_wgt_raddr));
            end
            pix_wait_q = i_pix_rd && !i_pix_grant;
            pix_addr_q = i_pix_raddr;
            wgt_wait_q = i_wgt_rd && !i_wgt_grant;
            wgt_addr_q = i_wgt_raddr;
            done_exp   = 1'b0;
            if (i_cfg_we && (i_cfg_addr == dnn_pkg::REG_START) && !busy_exp) begin
                busy_exp = 1'b1;
            end
            if (i_out_we && i_out_grant) begin
                record_write();
            end
        end
    end

endmodule

`default_nettype wire

//--- testbench/tb_dnn_mem_top.sv
// Testbench for the DNN memory subsystem with random memories and grants
`default_nettype none
`timescale 1ns/100ps

module tb_dnn_mem_top;

    localparam int ADDR_BITS  = 12;
    localparam int FIFO_DEPTH = 4;
    localparam int NUM_JOBS   = 8;
    localparam int MEM_WORDS  = 1 << ADDR_BITS;

    logic                          clk = 1'b0;
    logic                          rst_n = 1'b0;
    logic                          cfg_we;
    dnn_pkg::cfg_reg_e             cfg_addr;
    logic [dnn_pkg::WORD_BITS-1:0] cfg_wdata;
    logic                          pix_grant;
    logic [dnn_pkg::WORD_BITS-1:0] pix_rdata;
    logic                          wgt_grant;
    logic [dnn_pkg::WORD_BITS-1:0] wgt_rdata;
    logic                          out_grant;
    wire                           pix_rd;
    wire  [ADDR_BITS-1:0]          pix_raddr;
    wire                           wgt_rd;
    wire  [ADDR_BITS-1:0]          wgt_raddr;
    wire                           out_we;
    wire  [ADDR_BITS-1:0]          out_waddr;
    wire  [dnn_pkg::WORD_BITS-1:0] out_wdata;
    wire                           busy;
    wire                           done;

    logic [dnn_pkg::WORD_BITS-1:0] pix_mem [MEM_WORDS];
    logic [dnn_pkg::WORD_BITS-1:0] wgt_mem [MEM_WORDS];
    int                            job_count [NUM_JOBS];
    int                            cycles = 0;
    int                            cycle_limit = 0;
    int                            timeout_total;
    logic                          back_pressure = 1'b0;
    int                            stall_left = 0;
    logic                          pix_fire = 1'b0;
    logic [ADDR_BITS-1:0]          pix_addr_q = '0;
    logic                          wgt_fire = 1'b0;
    logic [ADDR_BITS-1:0]          wgt_addr_q = '0;

    dnn_mem_top #(.ADDR_BITS(ADDR_BITS), .FIFO_DEPTH(FIFO_DEPTH)) i_dut (
        .clk(clk), .i_rst_n(rst_n),
        .i_cfg_we(cfg_we), .i_cfg_addr(cfg_addr), .i_cfg_wdata(cfg_wdata),
        .i_pix_grant(pix_grant), .i_pix_rdata(pix_rdata),
        .i_wgt_grant(wgt_grant), .i_wgt_rdata(wgt_rdata), .i_out_grant(out_grant),
        .o_pix_rd(pix_rd), .o_pix_raddr(pix_raddr), .o_wgt_rd(wgt_rd), .o_wgt_raddr(wgt_raddr),
        .o_out_we(out_we), .o_out_waddr(out_waddr), .o_out_wdata(out_wdata),
        .o_busy(busy), .o_done(done)
    );

    dnn_checker #(.ADDR_BITS(ADDR_BITS)) u_checker (
        .clk(clk), .i_rst_n(rst_n), .i_cfg_we(cfg_we), .i_cfg_addr(cfg_addr),
        .i_pix_rd(pix_rd), .i_pix_raddr(pix_raddr), .i_pix_grant(pix_grant),
        .i_wgt_rd(wgt_rd), .i_wgt_raddr(wgt_raddr), .i_wgt_grant(wgt_grant),
        .i_out_we(out_we), .i_out_waddr(out_waddr), .i_out_wdata(out_wdata),
        .i_out_grant(out_grant), .i_busy(busy), .i_done(done)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    // Memory models return data one cycle after a granted read
    always @(negedge clk) begin
        pix_rdata = pix_fire ? pix_mem[pix_addr_q] : $urandom;
        wgt_rdata = wgt_fire ? wgt_mem[wgt_addr_q] : $urandom;
        pix_grant = rst_n && ($urandom_range(99, 0) < 70);
        wgt_grant = rst_n && ($urandom_range(99, 0) < 70);
        if (stall_left > 0) begin
            stall_left = stall_left - 1;
            out_grant  = 1'b0;
        end else begin
            if (back_pressure && ($urandom_range(3, 0) == 0)) begin
                stall_left = $urandom_range(12, 4);
            end
            out_grant = rst_n && ($urandom_range(99, 0) < 70);
        end
        pix_fire   = pix_rd && pix_grant;
        pix_addr_q = pix_raddr;
        wgt_fire   = wgt_rd && wgt_grant;
        wgt_addr_q = wgt_raddr;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, a job never finished", cycles);
            u_checker.finish_report(timeout_total);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic write_reg(input dnn_pkg::cfg_reg_e addr,
                             input logic [dnn_pkg::WORD_BITS-1:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(negedge clk);
        cfg_we    = 1'b0;
    endtask

    task automatic run_job(input logic [ADDR_BITS-1:0] pix_base,
                           input logic [ADDR_BITS-1:0] wgt_base,
                           input logic [ADDR_BITS-1:0] out_base, input int count,
                           input logic [dnn_pkg::SHIFT_BITS-1:0] shift);
        logic [ADDR_BITS-1:0] offset;
        u_checker.begin_job(out_base, count, shift);
        for (int i = 0; i < count; i++) begin
            offset = ADDR_BITS'(i);
            u_checker.expect_word(pix_mem[pix_base + offset], wgt_mem[wgt_base + offset]);
        end
        write_reg(dnn_pkg::REG_PIX_BASE, 32'(pix_base));
        write_reg(dnn_pkg::REG_WGT_BASE, 32'(wgt_base));
        write_reg(dnn_pkg::REG_OUT_BASE, 32'(out_base));
        write_reg(dnn_pkg::REG_COUNT, 32'(count));
        write_reg(dnn_pkg::REG_SHIFT, {28'd0, shift});
        write_reg(dnn_pkg::REG_START, 32'd0);
        // New values and a second start while the job runs
        @(negedge clk);
        write_reg(dnn_pkg::REG_SHIFT, {28'd0, ~shift});
        write_reg(dnn_pkg::REG_OUT_BASE, {20'd0, out_base + 12'd64});
        write_reg(dnn_pkg::REG_START, 32'd0);
        while (done !== 1'b1) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);
    endtask

    initial begin
        int sum;
        int total;
        void'($urandom(76));
        cfg_we    = 1'b0;
        cfg_addr  = dnn_pkg::REG_PIX_BASE;
        cfg_wdata = '0;
        pix_grant = 1'b0;
        pix_rdata = '0;
        wgt_grant = 1'b0;
        wgt_rdata = '0;
        out_grant = 1'b0;
        for (int a = 0; a < MEM_WORDS; a++) begin
            pix_mem[a] = $urandom;
            wgt_mem[a] = $urandom;
        end
        sum = 0;
        for (int j = 0; j < NUM_JOBS; j++) begin
            job_count[j] = $urandom_range(40, 1);
            sum = sum + job_count[j];
        end
        cycle_limit = sum * 20 + 200;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);
        for (int j = 0; j < NUM_JOBS; j++) begin
            back_pressure = j[0];
            run_job(ADDR_BITS'($urandom), ADDR_BITS'($urandom), ADDR_BITS'($urandom),
                    job_count[j], (j == 0) ? 4'd0 : 4'($urandom));
        end
        u_checker.finish_report(total);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dnn_mem_top.f
rtl/dnn_pkg.sv
rtl/dnn_credit_fifo.sv
rtl/dnn_cfg_regs.sv
rtl/dnn_read_dma.sv
rtl/dnn_mac_engine.sv
rtl/dnn_write_dma.sv
rtl/dnn_mem_top.sv
testbench/dnn_checker.sv
testbench/tb_dnn_mem_top.sv

//--- Makefile
SRCS := dnn_mem_top.f $(wildcard rtl/*.sv testbench/*.sv)

.PHONY: run clean

run: obj_dir/Vtb_dnn_mem_top
	obj_dir/Vtb_dnn_mem_top | tee sim.log
	grep -q "Testbench passed" sim.log

obj_dir/Vtb_dnn_mem_top: $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_dnn_mem_top \
		-f dnn_mem_top.f

clean:
	rm -rf obj_dir sim.log
